//--- src.f
csr_pkg.sv
rob_tracker.sv
csr_issue_queue.sv
preg_file.sv
csr_unit.sv
csr_backend.sv
csr_backend_asserts.sv
tb_csr_backend.sv

//--- tb_csr_backend.sv
`timescale 1ns/10ps
`default_nettype none

module tb_csr_backend
    import csr_pkg::*;
();

    typedef struct packed {
        logic [31:0] seq;  // Program order count.
        csr_disp_t   disp;
    } model_op_t;

    logic      clk;
    logic      rst;
    logic      disp_valid;
    logic      disp_ready;
    csr_disp_t disp;
    logic      ext_wr_valid;
    logic      ext_wr_ready;
    preg_wr_t  ext_wr;
    logic      redirect_valid;
    rob_idx_t  redirect_idx;
    logic      commit_valid;
    commit_t   commit;

    logic [XLEN-1:0] model_csr [CSR_NUM];
    logic [XLEN-1:0] model_preg [PREG_NUM];
    model_op_t       model_q [$];
    commit_t         exp_commit;
    int              next_seq = 0;
    int              seed = 32'h3c93175f;
    int              cycles = 0;
    int              disp_stalls = 0;
    int              ext_stalls = 0;

    csr_backend u_csr_backend (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Next surviving instruction in program order, applied to the model state.
    function automatic commit_t expect_commit();
        model_op_t       op;
        logic [XLEN-1:0] src;
        commit_t         exp;
        op          = model_q.pop_front();
        src         = model_preg[op.disp.rs1];
        exp.rob_idx = rob_idx_t'(op.seq[ROB_W:0]);  // Allocation count, wrap bit on top.
        exp.rd      = op.disp.rd;
        exp.old_val = model_csr[op.disp.csr_addr];
        case (op.disp.op)
            CSR_RW:  model_csr[op.disp.csr_addr] = src;
            CSR_RS:  model_csr[op.disp.csr_addr] = exp.old_val | src;
            CSR_RC:  model_csr[op.disp.csr_addr] = exp.old_val & ~src;
            default: model_csr[op.disp.csr_addr] = exp.old_val;
        endcase
        model_preg[op.disp.rd] = exp.old_val;
        return exp;
    endfunction

    task automatic stop_on_error();
        $display("Checks failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("ERR commit got %h expected %h", got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic dispatch_op(input csr_op_e kind, input logic [CSR_AW-1:0] addr,
                               input logic [PREG_W-1:0] rs1, input logic [PREG_W-1:0] rd);
        logic ready_seen;
        disp_valid = 1'b1;
        disp       = '{op: kind, csr_addr: addr, rs1: rs1, rd: rd};
        ready_seen = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            ready_seen = disp_ready;
            if (!disp_ready) begin
                disp_stalls++;
            end
            @(posedge clk);
        end
        model_q.push_back('{seq: next_seq, disp: disp});
        next_seq++;
        #2;
        disp_valid = 1'b0;
    endtask

    task automatic dispatch_random(input logic [PREG_W-1:0] mask, input logic [PREG_W-1:0] rd_base);
        logic [31:0] r;
        r = $random(seed);
        dispatch_op(csr_op_e'(2'(r[31:16] % 16'd3)), r[1:0], r[7:4] & mask,
                    rd_base | (r[11:8] & mask));
    endtask

    task automatic ext_write(input logic [PREG_W-1:0] tag, input logic [XLEN-1:0] data);
        logic ready_seen;
        ext_wr_valid = 1'b1;
        ext_wr       = '{tag: tag, data: data};
        ready_seen   = 1'b0;
        while (!ready_seen) begin
            @(negedge clk);
            ready_seen = ext_wr_ready;
            if (!ext_wr_ready) begin
                ext_stalls++;
            end
            @(posedge clk);
        end
        model_preg[tag] = data;
        #2;
        ext_wr_valid = 1'b0;
    endtask

    task automatic drain();
        while (model_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #2;
    endtask

    // RS with a zero source returns each CSR unchanged.
    task automatic read_csrs();
        ext_write(4'd15, '0);
        for (int i = 0; i < CSR_NUM; i++) begin
            dispatch_op(CSR_RS, CSR_AW'(i), 4'd15, 4'd14);
        end
        drain();
    endtask

    always @(negedge clk) begin
        if (!rst && commit_valid) begin
            if (model_q.size() == 0) begin
                $display("Commit arrived with no instruction outstanding");
                stop_on_error();
            end else begin
                exp_commit = expect_commit();
                check_commit(commit, exp_commit);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 3000) begin
            $display("Timeout after 3000 cycles with the tests still running");
            $display("Checks failed");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        logic [XLEN-1:0] src2;
        logic [31:0]     target;
        logic [XLEN-1:0] ext_data [PREG_NUM];
        rst            = 1'b1;
        disp_valid     = 1'b0;
        disp           = '0;
        ext_wr_valid   = 1'b0;
        ext_wr         = '0;
        redirect_valid = 1'b0;
        redirect_idx   = '0;
        for (int i = 0; i < CSR_NUM; i++) model_csr[i] = '0;
        for (int i = 0; i < PREG_NUM; i++) model_preg[i] = '0;
        @(negedge clk);
        check_flag("disp_ready", disp_ready, 1'b0);
        check_flag("commit_valid", commit_valid, 1'b0);
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < PREG_NUM; i++) ext_write(PREG_W'(i), $random(seed));
        src2 = model_preg[2];
        dispatch_op(CSR_RS, 2'd1, 4'd2, 4'd3);
        dispatch_op(CSR_RW, 2'd1, 4'd4, 4'd5);
        drain();
        check_data("preg[3]", u_csr_backend.u_preg_file.regs[3], '0);
        check_data("preg[5]", u_csr_backend.u_preg_file.regs[5], src2);
        repeat (60) dispatch_random(4'hf, 4'h0);
        drain();
        read_csrs();
        // Dispatch outruns one commit every three cycles.
        disp_stalls = 0;
        repeat (8) dispatch_random(4'hf, 4'h0);
        if (disp_stalls == 0) begin
            $display("Dispatch ready never dropped while the queue filled");
            stop_on_error();
        end
        drain();
        target = next_seq + 3;
        repeat (6) dispatch_random(4'hf, 4'h0);
        redirect_valid = 1'b1;
        redirect_idx   = rob_idx_t'(target[ROB_W:0]);
        @(posedge clk);
        while (model_q.size() != 0 && model_q[model_q.size() - 1].seq > target) begin
            model_q.delete(model_q.size() - 1);
        end
        next_seq = target + 1;  // Tracker tail restarts one past the redirect.
        #2;
        redirect_valid = 1'b0;
        repeat (2) dispatch_random(4'hf, 4'h0);
        drain();
        read_csrs();
        ext_stalls = 0;
        for (int i = 8; i < PREG_NUM; i++) ext_data[i] = $random(seed);
        fork
            repeat (8) dispatch_random(4'h3, 4'h4);
            for (int i = 8; i < PREG_NUM; i++) ext_write(PREG_W'(i), ext_data[i]);
        join
        if (ext_stalls == 0) begin
            $display("External write ready never dropped during writebacks");
            stop_on_error();
        end
        drain();
        for (int i = 8; i < PREG_NUM; i++) dispatch_op(CSR_RW, 2'd0, PREG_W'(i), 4'd4);
        drain();
        read_csrs();
        for (int i = 0; i < PREG_NUM; i++) begin
            check_data($sformatf("preg[%0d]", i), u_csr_backend.u_preg_file.regs[i],
                       model_preg[i]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- csr_backend_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csr_backend_asserts
    import csr_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      disp_valid,
    input logic      disp_ready,
    input csr_disp_t disp,
    input logic      commit_valid,
    input commit_t   commit
);

    rob_idx_t last_idx;
    logic     seen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen     <= 1'b0;
            last_idx <= '0;
        end else if (commit_valid) begin
            seen     <= 1'b1;
            last_idx <= commit.rob_idx;  // Most recent commit.
        end
    end

    disp_hold: assert property (@(posedge clk) disable iff (rst)
        disp_valid && !disp_ready |=> disp_valid && $stable(disp))
        else $error("Dispatch payload changed before the transfer");

    commit_pulse: assert property (@(posedge clk) disable iff (rst)
        commit_valid |=> !commit_valid)
        else $error("commit_valid high two cycles in a row");

    commit_order: assert property (@(posedge clk) disable iff (rst)
        commit_valid && seen |-> rob_older(last_idx, commit.rob_idx))
        else $error("Commit ROB index not younger than the previous commit");

endmodule

bind csr_backend csr_backend_asserts u_csr_backend_asserts (.*);

`default_nettype wire

//--- csr_backend.sv
`timescale 1ns/10ps
`default_nettype none

module csr_backend
    import csr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      disp_valid,
    output logic      disp_ready,
    input  csr_disp_t disp,
    input  logic      ext_wr_valid,
    output logic      ext_wr_ready,
    input  preg_wr_t  ext_wr,
    input  logic      redirect_valid,
    input  rob_idx_t  redirect_idx,
    output logic      commit_valid,
    output commit_t   commit
);

    logic              alloc_ready;
    rob_idx_t          alloc_idx;
    rob_idx_t          commit_head;
    logic              issue_valid;
    csr_issue_t        issue;
    logic [PREG_W-1:0] rd_addr;
    logic [XLEN-1:0]   rd_data;
    logic              wb_valid;
    preg_wr_t          wb;

    rob_tracker u_rob_tracker (
        .clk            (clk),
        .rst            (rst),
        .alloc_valid    (disp_valid & disp_ready),  // Dispatch handshake.
        .alloc_ready    (alloc_ready),
        .alloc_idx      (alloc_idx),
        .commit_valid   (commit_valid),
        .commit_head    (commit_head),
        .redirect_valid (redirect_valid),
        .redirect_idx   (redirect_idx)
    );

    csr_issue_queue u_csr_issue_queue (
        .clk            (clk),
        .rst            (rst),
        .disp_valid     (disp_valid),
        .disp_ready     (disp_ready),
        .disp           (disp),
        .alloc_idx      (alloc_idx),
        .alloc_ready    (alloc_ready),
        .commit_head    (commit_head),
        .redirect_valid (redirect_valid),
        .redirect_idx   (redirect_idx),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rd_addr        (rd_addr)
    );

    preg_file u_preg_file (
        .clk          (clk),
        .rst          (rst),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .wb_valid     (wb_valid),
        .wb           (wb),
        .ext_wr_valid (ext_wr_valid),
        .ext_wr       (ext_wr),
        .ext_wr_ready (ext_wr_ready)
    );

    csr_unit u_csr_unit (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue          (issue),
        .rd_data        (rd_data),
        .redirect_valid (redirect_valid),
        .redirect_idx   (redirect_idx),
        .wb_valid       (wb_valid),
        .wb             (wb),
        .commit_valid   (commit_valid),
        .commit         (commit)
    );

endmodule

`default_nettype wire

//--- csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_valid,
    input  csr_issue_t      issue,
    input  logic [XLEN-1:0] rd_data,
    input  logic            redirect_valid,
    input  rob_idx_t        redirect_idx,
    output logic            wb_valid,
    output preg_wr_t        wb,
    output logic            commit_valid,
    output commit_t         commit
);

    logic [XLEN-1:0]   csr_q [CSR_NUM];
    logic [XLEN-1:0]   old_val;
    logic [XLEN-1:0]   new_val;
    logic              kill_ex;
    logic              kill_wb;
    logic              pend_valid;
    logic [CSR_AW-1:0] pend_addr;
    logic [XLEN-1:0]   pend_data;
    logic              fire;

    assign old_val = csr_q[issue.disp.csr_addr];

    always_comb begin
        case (issue.disp.op)
            CSR_RS:  new_val = old_val | rd_data;
            CSR_RC:  new_val = old_val & ~rd_data;
            default: new_val = rd_data;
        endcase
    end

    // Killed when strictly younger than the redirect point.
    assign kill_ex = redirect_valid && rob_older(redirect_idx, issue.rob_idx);
    assign kill_wb = redirect_valid && rob_older(redirect_idx, commit.rob_idx);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pend_valid <= 1'b0;
        end else begin
            pend_valid <= issue_valid && !kill_ex;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            pend_addr      <= issue.disp.csr_addr;
            pend_data      <= new_val;
            commit.rob_idx <= issue.rob_idx;
            commit.rd      <= issue.disp.rd;
            commit.old_val <= old_val;
        end
    end

    assign fire         = pend_valid && !kill_wb;
    assign commit_valid = fire;
    assign wb_valid     = fire;
    assign wb.tag       = commit.rd;
    assign wb.data      = commit.old_val;  // Old CSR value goes to rd.

    // CSR lands with the commit pulse.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < CSR_NUM; i++) begin
                csr_q[i] <= '0;
            end
        end else if (fire) begin
            csr_q[pend_addr] <= pend_data;
        end
    end

endmodule

`default_nettype wire

//--- preg_file.sv
`timescale 1ns/10ps
`default_nettype none

module preg_file
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [PREG_W-1:0] rd_addr,
    output logic [XLEN-1:0]   rd_data,
    input  logic              wb_valid,
    input  preg_wr_t          wb,
    input  logic              ext_wr_valid,
    input  preg_wr_t          ext_wr,
    output logic              ext_wr_ready
);

    logic [XLEN-1:0] regs [PREG_NUM];
    logic            grant_wb;
    logic            grant_ext;
    logic            wr_en;
    preg_wr_t        wr;

    // Fixed priority, CSR writeback first.
    assign grant_wb     = wb_valid;
    assign grant_ext    = ext_wr_valid && !wb_valid;
    assign ext_wr_ready = !wb_valid;

    assign wr_en = grant_wb || grant_ext;
    assign wr    = grant_wb ? wb : ext_wr;

    assign rd_data = regs[rd_addr];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.tag] <= wr.data;
        end
    end

endmodule

`default_nettype wire

//--- csr_issue_queue.sv
`timescale 1ns/10ps
`default_nettype none

module csr_issue_queue
    import csr_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              disp_valid,
    output logic              disp_ready,
    input  csr_disp_t         disp,
    input  rob_idx_t          alloc_idx,
    input  logic              alloc_ready,
    input  rob_idx_t          commit_head,
    input  logic              redirect_valid,
    input  rob_idx_t          redirect_idx,
    output logic              issue_valid,
    output csr_issue_t        issue,
    output logic [PREG_W-1:0] rd_addr
);

    csr_issue_t        entries [IQ_SIZE];
    logic [IQ_W-1:0]   head;
    logic [IQ_W-1:0]   tail;
    logic              hdir;
    logic              tdir;
    logic [IQ_W:0]     head_ptr;
    logic [IQ_W:0]     tail_ptr;
    logic [IQ_W:0]     head_ptr_inc;
    logic [IQ_W:0]     tail_ptr_inc;
    logic [IQ_W:0]     count;
    logic [IQ_W:0]     keep_cnt;
    logic [IQ_W:0]     trim_ptr;
    logic              full;
    logic              empty;
    logic              enqueue;
    logic              select;

    // Direction bit on top of each pointer gives full and empty apart.
    assign head_ptr     = {hdir, head};
    assign tail_ptr     = {tdir, tail};
    assign head_ptr_inc = head_ptr + 1'b1;
    assign tail_ptr_inc = tail_ptr + 1'b1;
    assign count        = tail_ptr - head_ptr;

    assign full  = (head == tail) && (hdir != tdir);
    assign empty = (head == tail) && (hdir == tdir);

    assign disp_ready = !rst && !full && alloc_ready && !redirect_valid;  // Closed in reset.
    assign enqueue    = disp_valid && disp_ready;

    // Issue only once the head is the oldest uncommitted instruction.
    assign select = !empty && (entries[head].rob_idx == commit_head) && !redirect_valid;

    // Entries are in program order, so survivors of a redirect form a prefix from head.
    always_comb begin
        logic            stop;
        logic [IQ_W-1:0] pos;
        stop     = 1'b0;
        pos      = head;
        keep_cnt = '0;
        for (int k = 0; k < IQ_SIZE; k++) begin
            pos = head + IQ_W'(k);
            if (!stop && (k < count) && !rob_older(redirect_idx, entries[pos].rob_idx)) begin
                keep_cnt = keep_cnt + 1'b1;
            end else begin
                stop = 1'b1;
            end
        end
    end

    assign trim_ptr = head_ptr + keep_cnt;

    always_ff @(posedge clk) begin
        if (enqueue) begin
            entries[tail].disp    <= disp;
            entries[tail].rob_idx <= alloc_idx;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
            tdir <= 1'b0;
        end else if (redirect_valid) begin
            tail <= trim_ptr[IQ_W-1:0];  // Back to head when nothing survives.
            tdir <= trim_ptr[IQ_W];
        end else if (enqueue) begin
            tail <= tail_ptr_inc[IQ_W-1:0];
            tdir <= tail_ptr_inc[IQ_W];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            hdir <= 1'b0;
        end else if (select) begin
            head <= head_ptr_inc[IQ_W-1:0];
            hdir <= head_ptr_inc[IQ_W];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= select;
        end
    end

    always_ff @(posedge clk) begin
        if (select) begin
            issue <= entries[head];
        end
    end

    // Read address comes straight from the issue register.
    assign rd_addr = issue.disp.rs1;

endmodule

`default_nettype wire

//--- rob_tracker.sv
`timescale 1ns/10ps
`default_nettype none

module rob_tracker
    import csr_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     alloc_valid,
    output logic     alloc_ready,
    output rob_idx_t alloc_idx,
    input  logic     commit_valid,
    output rob_idx_t commit_head,
    input  logic     redirect_valid,
    input  rob_idx_t redirect_idx
);

    rob_idx_t tail;
    rob_idx_t head;
    rob_idx_t tail_inc;
    rob_idx_t head_inc;
    rob_idx_t redirect_inc;
    logic     full;

    // Power-of-two ROB, so a plain add carries into the direction bit.
    assign tail_inc     = rob_idx_t'(tail + 1'b1);
    assign head_inc     = rob_idx_t'(head + 1'b1);
    assign redirect_inc = rob_idx_t'(redirect_idx + 1'b1);

    assign full        = (tail.idx == head.idx) && (tail.dir != head.dir);
    assign alloc_ready = !full;
    assign alloc_idx   = tail;
    assign commit_head = head;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tail <= '0;
        end else if (redirect_valid) begin
            if (rob_older(redirect_idx, tail)) begin
                tail <= redirect_inc;  // Drop everything younger.
            end
        end else if (alloc_valid && alloc_ready) begin
            tail <= tail_inc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
        end else if (commit_valid) begin
            head <= head_inc;
        end
    end

endmodule

`default_nettype wire

//--- csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int PREG_NUM = 16;
    localparam int PREG_W   = 4;
    localparam int XLEN     = 32;
    localparam int ROB_SIZE = 8;
    localparam int ROB_W    = 3;
    localparam int IQ_SIZE  = 4;
    localparam int IQ_W     = 2;
    localparam int CSR_NUM  = 4;
    localparam int CSR_AW   = 2;

    // Direction bit flips each time the index wraps past ROB_SIZE-1.
    typedef struct packed {
        logic             dir;
        logic [ROB_W-1:0] idx;
    } rob_idx_t;

    typedef enum logic [1:0] {
        CSR_RW = 2'd0,  // Write source.
        CSR_RS = 2'd1,  // Set bits from source.
        CSR_RC = 2'd2   // Clear bits from source.
    } csr_op_e;

    typedef struct packed {
        csr_op_e           op;
        logic [CSR_AW-1:0] csr_addr;
        logic [PREG_W-1:0] rs1;
        logic [PREG_W-1:0] rd;
    } csr_disp_t;

    typedef struct packed {
        csr_disp_t disp;
        rob_idx_t  rob_idx;
    } csr_issue_t;

    typedef struct packed {
        logic [PREG_W-1:0] tag;
        logic [XLEN-1:0]   data;
    } preg_wr_t;

    typedef struct packed {
        rob_idx_t          rob_idx;
        logic [PREG_W-1:0] rd;
        logic [XLEN-1:0]   old_val;  // CSR value before the update.
    } commit_t;

    // True when a is strictly older than b in the wrapped ROB order.
    function automatic logic rob_older(input rob_idx_t a, input rob_idx_t b);
        logic older;
        if (a.dir == b.dir) begin
            older = a.idx < b.idx;
        end else begin
            older = a.idx > b.idx;
        end
        return older;
    endfunction

endpackage

`default_nettype wire
